/* verilog/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define XLEN 32

// ****************************************
// CSR numbers.
// ****************************************
`define CSR_MVENDORID   12'hf11
`define CSR_MARCHID     12'hf12
`define CSR_MIMPID      12'hf13
`define CSR_MHARTID     12'hf14
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MCOUNTEREN  12'h306
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344

// Identification registers are fixed for this hart.
`define VENDOR_ID       32'h0000_0000
`define ARCH_ID         32'h0000_0019
`define IMP_ID          32'h0001_0000
`define HART_ID         32'h0000_0000
`define MISA_VALUE      32'h4000_0100  // MXL is 1 for RV32 and only the I extension is set.

// ****************************************
// Write masks and field positions.
// ****************************************
`define MSTATUS_WMASK   32'h0000_0088
`define MIE_WMASK       32'h0000_0888
`define MTVEC_WMASK     32'hffff_fffd
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

`endif

/* verilog/csr_pkg.sv */
`include "csr_defs.svh"

package csr_pkg;

    // ****************************************
    // Basic word types.
    // ****************************************
    typedef logic [`XLEN-1:0] csr_data_t;
    typedef logic [11:0]      csr_num_t;
    typedef logic [`XLEN-1:0] csr_cause_t;  // Bit 31 set for interrupts.
    typedef logic [2:0]       irq_lines_t;

    // Order of the interrupt lines in irq_lines_t.
    localparam int unsigned IRQ_SW    = 0;
    localparam int unsigned IRQ_TIMER = 1;
    localparam int unsigned IRQ_EXT   = 2;

    // Matching pending bits in mip and enable bits in mie.
    localparam int unsigned MIP_MSIP_BIT = 3;
    localparam int unsigned MIP_MTIP_BIT = 7;
    localparam int unsigned MIP_MEIP_BIT = 11;

    localparam int unsigned CAUSE_INT_BIT = `XLEN - 1;

    // ****************************************
    // Trap request from the core.
    // ****************************************
    // The fields only count while the one-cycle valid pulse is high.
    typedef struct packed {
        logic       valid;
        csr_cause_t cause;
        csr_data_t  epc;
        csr_data_t  tval;
    } trap_req_t;

endpackage

/* verilog/apb_pkg.sv */
package apb_pkg;

    // Request side of the APB slave port, driven by the bus master.
    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        csr_pkg::csr_num_t  paddr;   // CSR number used directly as address.
        csr_pkg::csr_data_t pwdata;
    } apb_req_t;

    // Response side, driven by the CSR unit.
    typedef struct packed {
        csr_pkg::csr_data_t prdata;
        logic               pready;
        logic               pslverr;
    } apb_rsp_t;

endpackage

/* verilog/csr_apb_port.sv */
module csr_apb_port
    import csr_pkg::*;
    import apb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_req_t  apb_req,
    input  logic      rd_hit,
    input  logic      wr_hit,
    input  csr_data_t rd_data,
    output apb_rsp_t  apb_rsp,
    output csr_num_t  csr_num,
    output logic      rd_en,
    output logic      wr_en,
    output csr_data_t wr_data
);

    logic setup;
    logic access;
    logic hit;
    logic ready_q;
    logic err_q;
    logic rd_ok_q;

    // ****************************************
    // Phase detection and strobes.
    // ****************************************
    assign setup  = apb_req.psel & ~apb_req.penable;
    assign access = apb_req.psel & apb_req.penable;
    assign hit    = apb_req.pwrite ? wr_hit : rd_hit;

    assign csr_num = apb_req.paddr;
    assign wr_data = apb_req.pwdata;

    // The read value is captured during setup so it is ready in the access cycle.
    assign rd_en = setup & ~apb_req.pwrite;
    assign wr_en = access & apb_req.pwrite & wr_hit;

    // ****************************************
    // Response.
    // ****************************************
    // Every setup is followed by exactly one access cycle, so the response
    // flags are simply the setup decode delayed by one clock.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
            err_q   <= 1'b0;
            rd_ok_q <= 1'b0;
        end else begin
            ready_q <= setup;
            err_q   <= setup & ~hit;
            rd_ok_q <= setup & ~apb_req.pwrite & rd_hit;
        end
    end

    // Writes and failed reads return zero.
    assign apb_rsp.prdata  = rd_ok_q ? rd_data : '0;
    assign apb_rsp.pready  = ready_q;
    assign apb_rsp.pslverr = err_q;

endmodule

/* verilog/csr_trap_regs.sv */
`include "csr_defs.svh"

module csr_trap_regs
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  csr_num_t   csr_num,
    input  logic       wr_en,
    input  csr_data_t  wr_data,
    input  trap_req_t  trap,
    input  logic       mret,
    input  irq_lines_t irq_lines,
    output logic       wr_hit,
    output csr_data_t  mstatus,
    output csr_data_t  mie,
    output csr_data_t  mip,
    output csr_data_t  mtvec,
    output csr_data_t  mcounteren,
    output csr_data_t  mscratch,
    output csr_data_t  mepc,
    output csr_data_t  mcause,
    output csr_data_t  mtval,
    output csr_data_t  trap_pc,
    output logic       irq_req
);

    logic      wr_ok;
    csr_data_t mip_next;
    csr_data_t tvec_base;

    // ****************************************
    // Write decode.
    // ****************************************
    always_comb begin
        case (csr_num)
            `CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MCOUNTEREN,
            `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL: wr_hit = 1'b1;
            default: wr_hit = 1'b0;
        endcase
    end

    assign wr_ok = wr_en & ~trap.valid;  // A trap in the same cycle drops the write.

    // ****************************************
    // Register bank.
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= '0;
        end else if (trap.valid) begin
            mstatus[`MSTATUS_MPIE_BIT] <= mstatus[`MSTATUS_MIE_BIT];
            mstatus[`MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (mret) begin
            mstatus[`MSTATUS_MIE_BIT]  <= mstatus[`MSTATUS_MPIE_BIT];
            mstatus[`MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (wr_ok && csr_num == `CSR_MSTATUS) begin
            mstatus <= wr_data & `MSTATUS_WMASK;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie        <= '0;
            mtvec      <= '0;
            mcounteren <= '0;
            mscratch   <= '0;
        end else if (wr_ok) begin
            case (csr_num)
                `CSR_MIE:        mie        <= wr_data & `MIE_WMASK;
                `CSR_MTVEC:      mtvec      <= wr_data & `MTVEC_WMASK;
                `CSR_MCOUNTEREN: mcounteren <= wr_data;
                `CSR_MSCRATCH:   mscratch   <= wr_data;
                default: ;
            endcase
        end
    end

    // Trap handling registers, loaded by the core on a trap or by software.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (trap.valid) begin
            mepc   <= trap.epc;
            mcause <= trap.cause;
            mtval  <= trap.tval;
        end else if (wr_ok) begin
            case (csr_num)
                `CSR_MEPC:   mepc   <= wr_data;
                `CSR_MCAUSE: mcause <= wr_data;
                `CSR_MTVAL:  mtval  <= wr_data;
                default: ;
            endcase
        end
    end

    // ****************************************
    // Interrupts.
    // ****************************************
    always_comb begin
        mip_next               = '0;
        mip_next[MIP_MSIP_BIT] = irq_lines[IRQ_SW];
        mip_next[MIP_MTIP_BIT] = irq_lines[IRQ_TIMER];
        mip_next[MIP_MEIP_BIT] = irq_lines[IRQ_EXT];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip     <= '0;
            irq_req <= 1'b0;
        end else begin
            mip     <= mip_next;
            irq_req <= mstatus[`MSTATUS_MIE_BIT] & (|(mip & mie));
        end
    end

    // Only interrupts use vectored mode. Exceptions always go to the base.
    assign tvec_base = {mtvec[`XLEN-1:2], 2'b00};
    assign trap_pc   = (mtvec[0] && trap.cause[CAUSE_INT_BIT])
                     ? tvec_base + {trap.cause[`XLEN-3:0], 2'b00}
                     : tvec_base;

endmodule

/* verilog/csr_read_sel.sv */
`include "csr_defs.svh"

module csr_read_sel
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  csr_num_t  csr_num,
    input  logic      rd_en,
    input  csr_data_t mstatus,
    input  csr_data_t mie,
    input  csr_data_t mip,
    input  csr_data_t mtvec,
    input  csr_data_t mcounteren,
    input  csr_data_t mscratch,
    input  csr_data_t mepc,
    input  csr_data_t mcause,
    input  csr_data_t mtval,
    output logic      rd_hit,
    output csr_data_t rd_data
);

    csr_data_t sel;

    // ****************************************
    // Read decode.
    // ****************************************
    always_comb begin
        rd_hit = 1'b1;
        case (csr_num)
            `CSR_MVENDORID:  sel = `VENDOR_ID;
            `CSR_MARCHID:    sel = `ARCH_ID;
            `CSR_MIMPID:     sel = `IMP_ID;
            `CSR_MHARTID:    sel = `HART_ID;
            `CSR_MSTATUS:    sel = mstatus;
            `CSR_MISA:       sel = `MISA_VALUE;
            `CSR_MIE:        sel = mie;
            `CSR_MTVEC:      sel = mtvec;
            `CSR_MCOUNTEREN: sel = mcounteren;
            `CSR_MSCRATCH:   sel = mscratch;
            `CSR_MEPC:       sel = mepc;
            `CSR_MCAUSE:     sel = mcause;
            `CSR_MTVAL:      sel = mtval;
            `CSR_MIP:        sel = mip;
            default: begin
                rd_hit = 1'b0;
                sel    = '0;  // Unmapped numbers read as zero.
            end
        endcase
    end

    // Captured in the setup cycle and held for the access cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= sel;
        end
    end

endmodule

/* verilog/csr_unit.sv */
module csr_unit
    import csr_pkg::*;
    import apb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  trap_req_t  trap,
    input  logic       mret,
    input  irq_lines_t irq_lines,
    output csr_data_t  trap_pc,
    output csr_data_t  epc,
    output logic       irq_req
);

    csr_num_t  csr_num;
    logic      rd_en;
    logic      wr_en;
    logic      rd_hit;
    logic      wr_hit;
    csr_data_t wr_data;
    csr_data_t rd_data;
    csr_data_t mstatus;
    csr_data_t mie;
    csr_data_t mip;
    csr_data_t mtvec;
    csr_data_t mcounteren;
    csr_data_t mscratch;
    csr_data_t mepc;
    csr_data_t mcause;
    csr_data_t mtval;

    // ****************************************
    // Bus port, register bank, read mux.
    // ****************************************
    csr_apb_port port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .rd_hit  (rd_hit),
        .wr_hit  (wr_hit),
        .rd_data (rd_data),
        .apb_rsp (apb_rsp),
        .csr_num (csr_num),
        .rd_en   (rd_en),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    csr_trap_regs regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_num    (csr_num),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .trap       (trap),
        .mret       (mret),
        .irq_lines  (irq_lines),
        .wr_hit     (wr_hit),
        .mstatus    (mstatus),
        .mie        (mie),
        .mip        (mip),
        .mtvec      (mtvec),
        .mcounteren (mcounteren),
        .mscratch   (mscratch),
        .mepc       (mepc),
        .mcause     (mcause),
        .mtval      (mtval),
        .trap_pc    (trap_pc),
        .irq_req    (irq_req)
    );

    csr_read_sel sel_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_num    (csr_num),
        .rd_en      (rd_en),
        .mstatus    (mstatus),
        .mie        (mie),
        .mip        (mip),
        .mtvec      (mtvec),
        .mcounteren (mcounteren),
        .mscratch   (mscratch),
        .mepc       (mepc),
        .mcause     (mcause),
        .mtval      (mtval),
        .rd_hit     (rd_hit),
        .rd_data    (rd_data)
    );

    assign epc = mepc;  // Return address for mret.

endmodule

/* verification/clk_rst_gen.sv */
module clk_rst_gen #(
    parameter int unsigned RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    // Released just after an edge, in step with the other inputs.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

/* verification/csr_unit_chk.sv */
`include "csr_defs.svh"

module csr_unit_chk
    import csr_pkg::*;
    import apb_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input apb_req_t   apb_req,
    input apb_rsp_t   apb_rsp,
    input trap_req_t  trap,
    input logic       mret,
    input irq_lines_t irq_lines,
    input csr_data_t  trap_pc,
    input csr_data_t  epc,
    input logic       irq_req
);
    timeunit 1ns;
    timeprecision 100ps;

    csr_data_t      mstatus_s, mie_s, mip_s, mtvec_s, mcounteren_s;
    csr_data_t      mscratch_s, mepc_s, mcause_s, mtval_s;
    logic [`XLEN:0] exp_rd;  // Error flag on top of the expected read data.
    logic           irq_exp;
    logic           failed = 1'b0;
    logic           setup;
    logic           access;

    assign setup  = apb_req.psel & ~apb_req.penable;
    assign access = apb_req.psel & apb_req.penable;

    // ****************************************
    // Reference model.
    // ****************************************
    function automatic logic [`XLEN:0] model_read(csr_num_t n);
        case (n)
            `CSR_MVENDORID:  return {1'b0, `VENDOR_ID};
            `CSR_MARCHID:    return {1'b0, `ARCH_ID};
            `CSR_MIMPID:     return {1'b0, `IMP_ID};
            `CSR_MHARTID:    return {1'b0, `HART_ID};
            `CSR_MISA:       return {1'b0, `MISA_VALUE};
            `CSR_MSTATUS:    return {1'b0, mstatus_s};
            `CSR_MIE:        return {1'b0, mie_s};
            `CSR_MIP:        return {1'b0, mip_s};
            `CSR_MTVEC:      return {1'b0, mtvec_s};
            `CSR_MCOUNTEREN: return {1'b0, mcounteren_s};
            `CSR_MSCRATCH:   return {1'b0, mscratch_s};
            `CSR_MEPC:       return {1'b0, mepc_s};
            `CSR_MCAUSE:     return {1'b0, mcause_s};
            `CSR_MTVAL:      return {1'b0, mtval_s};
            default:         return {1'b1, csr_data_t'(0)};
        endcase
    endfunction

    function automatic logic model_writable(csr_num_t n);
        return n inside {`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MCOUNTEREN,
                         `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL};
    endfunction

    // Interrupts with vectored mode jump four bytes per cause code.
    function automatic csr_data_t model_trap_pc(csr_data_t tvec, csr_cause_t cause);
        if (tvec[0] && cause[`XLEN-1])
            return {tvec[`XLEN-1:2], 2'b00} + ((cause & 32'h7fff_ffff) << 2);
        return {tvec[`XLEN-1:2], 2'b00};
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {mstatus_s, mie_s, mip_s, mtvec_s, mcounteren_s} <= '0;
            {mscratch_s, mepc_s, mcause_s, mtval_s} <= '0;
            exp_rd  <= '0;
            irq_exp <= 1'b0;
        end else begin
            mip_s   <= {20'b0, irq_lines[2], 3'b0, irq_lines[1], 3'b0, irq_lines[0], 3'b0};
            irq_exp <= mstatus_s[`MSTATUS_MIE_BIT] && ((mip_s & mie_s) != '0);
            if (setup)
                exp_rd <= apb_req.pwrite ? {~model_writable(apb_req.paddr), csr_data_t'(0)}
                                         : model_read(apb_req.paddr);
            if (trap.valid) begin
                mepc_s   <= trap.epc;
                mcause_s <= trap.cause;
                mtval_s  <= trap.tval;
                mstatus_s[`MSTATUS_MPIE_BIT] <= mstatus_s[`MSTATUS_MIE_BIT];
                mstatus_s[`MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (mret) begin
                mstatus_s[`MSTATUS_MIE_BIT]  <= mstatus_s[`MSTATUS_MPIE_BIT];
                mstatus_s[`MSTATUS_MPIE_BIT] <= 1'b1;
            end else if (access && apb_req.pwrite) begin
                case (apb_req.paddr)
                    `CSR_MSTATUS:    mstatus_s    <= apb_req.pwdata & `MSTATUS_WMASK;
                    `CSR_MIE:        mie_s        <= apb_req.pwdata & `MIE_WMASK;
                    `CSR_MTVEC:      mtvec_s      <= apb_req.pwdata & `MTVEC_WMASK;
                    `CSR_MCOUNTEREN: mcounteren_s <= apb_req.pwdata;
                    `CSR_MSCRATCH:   mscratch_s   <= apb_req.pwdata;
                    `CSR_MEPC:       mepc_s       <= apb_req.pwdata;
                    `CSR_MCAUSE:     mcause_s     <= apb_req.pwdata;
                    `CSR_MTVAL:      mtval_s      <= apb_req.pwdata;
                    default: ;
                endcase
            end
        end
    end

    // ****************************************
    // Assertions.
    // ****************************************
    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pready == access)
        else begin
            $error("error apb_rsp.pready got %h expected %h",
                   $sampled(apb_rsp.pready), $sampled(access));
            failed = 1'b1;
        end

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr == (access && exp_rd[`XLEN]))
        else begin
            $error("error apb_rsp.pslverr got %h expected %h",
                   $sampled(apb_rsp.pslverr), $sampled(access && exp_rd[`XLEN]));
            failed = 1'b1;
        end

    a_prdata: assert property (@(posedge clk) disable iff (!rst_n)
        access |-> apb_rsp.prdata == exp_rd[`XLEN-1:0])
        else begin
            $error("error apb_rsp.prdata got %h expected %h",
                   $sampled(apb_rsp.prdata), $sampled(exp_rd[`XLEN-1:0]));
            failed = 1'b1;
        end

    a_epc: assert property (@(posedge clk) disable iff (!rst_n) epc == mepc_s)
        else begin
            $error("error epc got %h expected %h", $sampled(epc), $sampled(mepc_s));
            failed = 1'b1;
        end

    a_trap_pc: assert property (@(posedge clk) disable iff (!rst_n)
        trap.valid |-> trap_pc == model_trap_pc(mtvec_s, trap.cause))
        else begin
            $error("error trap_pc got %h expected %h", $sampled(trap_pc),
                   model_trap_pc($sampled(mtvec_s), $sampled(trap.cause)));
            failed = 1'b1;
        end

    a_irq_req: assert property (@(posedge clk) disable iff (!rst_n) irq_req == irq_exp)
        else begin
            $error("error irq_req got %h expected %h", $sampled(irq_req), $sampled(irq_exp));
            failed = 1'b1;
        end

endmodule

/* verification/csr_unit_tb.sv */
`include "csr_defs.svh"

module csr_unit_tb
    import csr_pkg::*;
    import apb_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Rough sum of the cycles spent by the sequence below.
    localparam int unsigned TEST_CYCLES    = 225;
    localparam int unsigned TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    trap_req_t   trap;
    logic        mret;
    irq_lines_t  irq_lines;
    csr_data_t   trap_pc;
    csr_data_t   epc;
    logic        irq_req;
    logic [31:0] lfsr_state = 32'h2fd1_c375;
    int unsigned cycle_count = 0;

    csr_num_t all_regs [14] = '{`CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID,
                                `CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC,
                                `CSR_MCOUNTEREN, `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE,
                                `CSR_MTVAL, `CSR_MIP};
    csr_num_t rw_regs [8]   = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MCOUNTEREN,
                                `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL};
    csr_num_t ro_regs [5]   = '{`CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID,
                                `CSR_MISA};
    csr_num_t trap_csrs [4] = '{`CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MSTATUS};

    clk_rst_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    csr_unit dut_i (.*);

    bind csr_unit csr_unit_chk chk_i (.*);

    // ****************************************
    // Helpers.
    // ****************************************
    // Fibonacci LFSR with taps 32, 22, 2 and 1. It steps once for each bit taken.
    function automatic logic [31:0] rand_bits(int unsigned n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic idle(int unsigned n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // A transfer takes one setup and one access cycle and starts and ends 10 ns after an edge.
    task automatic apb_xfer(logic write, csr_num_t addr, csr_data_t data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        idle(1);
        apb_req.penable = 1'b1;
        while (!apb_rsp.pready) idle(1);
        idle(1);
        apb_req = '0;
    endtask

    task automatic apb_write(csr_num_t addr, csr_data_t data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic apb_read(csr_num_t addr);
        apb_xfer(1'b0, addr, '0);
    endtask

    task automatic pulse_trap(csr_cause_t cause);
        trap = '{valid: 1'b1, cause: cause, epc: rand_bits(32), tval: rand_bits(32)};
        idle(1);
        trap = '0;
    endtask

    task automatic pulse_mret();
        mret = 1'b1;
        idle(1);
        mret = 1'b0;
    endtask

    // ****************************************
    // Watchdogs.
    // ****************************************
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run("timeout: tests did not finish");
    end

    initial begin
        wait (dut_i.chk_i.failed === 1'b1);
        abort_run("a checker assertion failed");
    end

    // ****************************************
    // Test sequence.
    // ****************************************
    initial begin
        apb_req   = '0;
        trap      = '0;
        mret      = 1'b0;
        irq_lines = '0;
        wait (rst_n === 1'b1);
        idle(2);
        foreach (all_regs[i]) apb_read(all_regs[i]);  // Reset values and read map.
        apb_read(12'h7c0);
        repeat (2) begin
            foreach (rw_regs[i]) begin
                apb_write(rw_regs[i], rand_bits(32));
                apb_read(rw_regs[i]);
            end
        end
        foreach (ro_regs[i]) begin
            apb_write(ro_regs[i], rand_bits(32));
            apb_read(ro_regs[i]);
        end
        apb_write(12'h7c0, rand_bits(32));
        // Exceptions and interrupts under both mtvec modes, each followed by mret.
        for (int mode = 0; mode < 2; mode++) begin
            for (int intr = 0; intr < 2; intr++) begin
                apb_write(`CSR_MTVEC, {30'(rand_bits(30)), 1'b0, mode[0]});
                // MIE takes both values before a trap.
                apb_write(`CSR_MSTATUS, {28'(rand_bits(28)), intr[0] ^ mode[0],
                                         3'(rand_bits(3))});
                pulse_trap({intr[0], 27'b0, 4'(rand_bits(4))});
                foreach (trap_csrs[i]) apb_read(trap_csrs[i]);
                pulse_mret();
                apb_read(`CSR_MSTATUS);
            end
        end
        apb_write(`CSR_MIE, `MIE_WMASK);
        apb_write(`CSR_MSTATUS, 32'h8);
        for (int line = 0; line < 3; line++) begin
            irq_lines = irq_lines_t'(1 << line);
            idle(3);
            irq_lines = '0;
            idle(3);
        end
        irq_lines = 3'b111;
        idle(3);
        apb_write(`CSR_MSTATUS, 32'h0);  // Global enable off with lines still pending.
        idle(3);
        apb_write(`CSR_MIE, 32'h0);
        apb_write(`CSR_MSTATUS, 32'h8);  // Global enable back on with every line masked.
        idle(3);
        irq_lines = '0;
        idle(2);
        if (dut_i.chk_i.failed) begin
            abort_run("a checker assertion failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* csr_unit.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/apb_pkg.sv
verilog/csr_apb_port.sv
verilog/csr_trap_regs.sv
verilog/csr_read_sel.sv
verilog/csr_unit.sv
verification/clk_rst_gen.sv
verification/csr_unit_chk.sv
verification/csr_unit_tb.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/csr_pkg.sv
      - verilog/apb_pkg.sv
      - verilog/csr_apb_port.sv
      - verilog/csr_trap_regs.sv
      - verilog/csr_read_sel.sv
      - verilog/csr_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/clk_rst_gen.sv
      - verification/csr_unit_chk.sv
      - verification/csr_unit_tb.sv
